// ==== hw/mips_pkg.sv ====
package mips_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // primary opcode in bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f
    } opcode_t;

    // SPECIAL function field in bits 5:0
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_and, alu_or, alu_xor, alu_nor,
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra
    } alu_op_t;

    // APB byte addresses
    localparam logic [7:0] addr_instr    = 8'h00;
    localparam logic [7:0] addr_status   = 8'h04;
    localparam logic [7:0] addr_reg_base = 8'h80; // reg n at base + 4n

    localparam int status_undef_bit = 0;
    localparam int status_ovf_bit   = 1;

endpackage

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  mips_pkg::word_t     instr,
    output logic                dec_valid,
    output mips_pkg::alu_op_t   alu_op,
    output logic                var_shift,
    output logic                use_imm,
    output logic                reg_write,
    output logic                undefined,
    output mips_pkg::word_t     imm,
    output logic [4:0]          shamt,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output mips_pkg::reg_addr_t waddr
);

    mips_pkg::opcode_t   opc;
    mips_pkg::funct_t    fn;
    mips_pkg::alu_op_t   op_c;
    mips_pkg::word_t     imm_val;
    mips_pkg::reg_addr_t rs_c;
    mips_pkg::reg_addr_t waddr_c;
    logic                var_c;
    logic                regw_c;
    logic                undef_c;

    assign opc = mips_pkg::opcode_t'(instr[31:26]);
    assign fn  = mips_pkg::funct_t'(instr[5:0]);

    always_comb begin
        if (opc == mips_pkg::op_lui) begin
            imm_val = {instr[15:0], 16'h0000};
        end else if (instr[29:28] == 2'b11) begin
            imm_val = {16'h0000, instr[15:0]};     // andi, ori, xori
        end else begin
            imm_val = {{16{instr[15]}}, instr[15:0]};
        end
    end

    always_comb begin
        op_c    = mips_pkg::alu_addu;
        var_c   = 1'b0;
        regw_c  = 1'b1;
        undef_c = 1'b0;
        rs_c    = instr[25:21];
        waddr_c = instr[20:16];                    // rt for I-type
        case (opc)
            mips_pkg::op_special: begin
                waddr_c = instr[15:11];
                case (fn)
                    mips_pkg::fn_and:  op_c = mips_pkg::alu_and;
                    mips_pkg::fn_or:   op_c = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  op_c = mips_pkg::alu_xor;
                    mips_pkg::fn_nor:  op_c = mips_pkg::alu_nor;
                    mips_pkg::fn_add:  op_c = mips_pkg::alu_add;
                    mips_pkg::fn_addu: op_c = mips_pkg::alu_addu;
                    mips_pkg::fn_sub:  op_c = mips_pkg::alu_sub;
                    mips_pkg::fn_subu: op_c = mips_pkg::alu_subu;
                    mips_pkg::fn_slt:  op_c = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: op_c = mips_pkg::alu_sltu;
                    mips_pkg::fn_sll:  op_c = mips_pkg::alu_sll;
                    mips_pkg::fn_srl:  op_c = mips_pkg::alu_srl;
                    mips_pkg::fn_sra:  op_c = mips_pkg::alu_sra;
                    mips_pkg::fn_sllv: begin
                        op_c  = mips_pkg::alu_sll;
                        var_c = 1'b1;
                    end
                    mips_pkg::fn_srlv: begin
                        op_c  = mips_pkg::alu_srl;
                        var_c = 1'b1;
                    end
                    mips_pkg::fn_srav: begin
                        op_c  = mips_pkg::alu_sra;
                        var_c = 1'b1;
                    end
                    default: begin
                        regw_c  = 1'b0;
                        undef_c = 1'b1;
                    end
                endcase
            end
            mips_pkg::op_addi:  op_c = mips_pkg::alu_add;
            mips_pkg::op_addiu: op_c = mips_pkg::alu_addu;
            mips_pkg::op_slti:  op_c = mips_pkg::alu_slt;
            mips_pkg::op_sltiu: op_c = mips_pkg::alu_sltu;
            mips_pkg::op_andi:  op_c = mips_pkg::alu_and;
            mips_pkg::op_ori:   op_c = mips_pkg::alu_or;
            mips_pkg::op_xori:  op_c = mips_pkg::alu_xor;
            mips_pkg::op_lui: begin
                op_c = mips_pkg::alu_or;
                rs_c = '0;                         // r0 reads zero so the result is imm
            end
            default: begin
                regw_c  = 1'b0;
                undef_c = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            reg_write <= 1'b0;
            undefined <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
            if (instr_valid) begin
                reg_write <= regw_c;
                undefined <= undef_c;
            end
        end
    end

    // operand fields for execute
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            alu_op    <= op_c;
            var_shift <= var_c;
            use_imm   <= (opc != mips_pkg::op_special);
            imm       <= imm_val;
            shamt     <= instr[10:6];
            rs        <= rs_c;
            rt        <= instr[20:16];
            waddr     <= waddr_c;
        end
    end

endmodule

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                dec_valid,
    input  mips_pkg::alu_op_t   alu_op,
    input  logic                var_shift,
    input  logic                use_imm,
    input  logic                reg_write,
    input  logic                undefined,
    input  mips_pkg::word_t     imm,
    input  logic [4:0]          shamt,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    output logic                ex_valid,
    output mips_pkg::word_t     ex_result,
    output mips_pkg::reg_addr_t ex_waddr,
    output logic                ex_write,
    output logic                ex_overflow,
    output logic                ex_undefined
);

    mips_pkg::word_t op_b;
    mips_pkg::word_t res;
    logic [32:0]     sum;
    logic [32:0]     diff;
    logic [4:0]      sa;
    logic            ovf;

    assign op_b = use_imm ? imm : rt_data;
    assign sa   = var_shift ? rs_data[4:0] : shamt;

    // one extra sign bit to catch signed overflow
    assign sum  = {rs_data[31], rs_data} + {op_b[31], op_b};
    assign diff = {rs_data[31], rs_data} - {op_b[31], op_b};

    always_comb begin
        ovf = 1'b0;
        case (alu_op)
            mips_pkg::alu_and:  res = rs_data & op_b;
            mips_pkg::alu_or:   res = rs_data | op_b;
            mips_pkg::alu_xor:  res = rs_data ^ op_b;
            mips_pkg::alu_nor:  res = ~(rs_data | op_b);
            mips_pkg::alu_add: begin
                res = sum[31:0];
                ovf = sum[32] ^ sum[31];
            end
            mips_pkg::alu_addu: res = sum[31:0];
            mips_pkg::alu_sub: begin
                res = diff[31:0];
                ovf = diff[32] ^ diff[31];
            end
            mips_pkg::alu_subu: res = diff[31:0];
            mips_pkg::alu_slt:  res = {31'd0, $signed(rs_data) < $signed(op_b)};
            mips_pkg::alu_sltu: res = {31'd0, rs_data < op_b};
            mips_pkg::alu_sll:  res = rt_data << sa;
            mips_pkg::alu_srl:  res = rt_data >> sa;
            mips_pkg::alu_sra:  res = $signed(rt_data) >>> sa;
            default:            res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_write     <= 1'b0;
            ex_overflow  <= 1'b0;
            ex_undefined <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid) begin
                ex_write     <= reg_write & ~ovf;  // overflow leaves rd untouched
                ex_overflow  <= ovf;
                ex_undefined <= undefined;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_result <= res;
            ex_waddr  <= waddr;
        end
    end

endmodule

// ==== hw/reg_writeback.sv ====
`timescale 1ns/1ps

module reg_writeback (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                ex_valid,
    input  mips_pkg::word_t     ex_result,
    input  mips_pkg::reg_addr_t ex_waddr,
    input  logic                ex_write,
    input  logic                ex_overflow,
    input  logic                ex_undefined,
    input  logic                host_we,
    input  mips_pkg::reg_addr_t host_addr,
    input  mips_pkg::word_t     host_wdata,
    input  logic                status_clear,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     host_rdata,
    output logic                wb_done,
    output logic [1:0]          status
);

    mips_pkg::word_t regs [1:31];    // r0 has no storage

    function automatic mips_pkg::word_t rd_port(input mips_pkg::reg_addr_t a);
        return (a == '0) ? '0 : regs[a];
    endfunction

    assign rs_data    = rd_port(rs);
    assign rt_data    = rd_port(rt);
    assign host_rdata = rd_port(host_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_valid && ex_write && ex_waddr != '0) begin
            regs[ex_waddr] <= ex_result;
        end else if (host_we && host_addr != '0) begin
            regs[host_addr] <= host_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status  <= '0;
            wb_done <= 1'b0;
        end else begin
            wb_done <= ex_valid;
            if (status_clear) begin
                status <= '0;
            end else if (ex_valid) begin
                // sticky until the host clears them
                status[mips_pkg::status_undef_bit] <=
                    status[mips_pkg::status_undef_bit] | ex_undefined;
                status[mips_pkg::status_ovf_bit] <=
                    status[mips_pkg::status_ovf_bit] | ex_overflow;
            end
        end
    end

endmodule

// ==== hw/apb_front.sv ====
`timescale 1ns/1ps

module apb_front #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  mips_pkg::word_t       pwdata,
    output mips_pkg::word_t       prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  wb_done,
    input  mips_pkg::word_t       host_rdata,
    input  logic [1:0]            status,
    output logic                  instr_valid,
    output mips_pkg::word_t       instr,
    output logic                  host_we,
    output mips_pkg::reg_addr_t   host_addr,
    output mips_pkg::word_t       host_wdata,
    output logic                  status_clear
);

    typedef enum logic {
        idle,
        wait_exec
    } state_t;

    // register index bits 6:2 inside the window
    localparam logic [ADDR_WIDTH-1:0] reg_idx_mask = ADDR_WIDTH'(8'h7c);

    state_t state;
    logic   access;
    logic   is_instr;
    logic   is_status;
    logic   is_reg;

    assign access    = psel & penable;
    assign is_instr  = (paddr == ADDR_WIDTH'(mips_pkg::addr_instr));
    assign is_status = (paddr == ADDR_WIDTH'(mips_pkg::addr_status));
    assign is_reg    = ((paddr & ~reg_idx_mask) == ADDR_WIDTH'(mips_pkg::addr_reg_base));

    // first access cycle of an instruction write
    assign instr_valid  = access & pwrite & is_instr & (state == idle);
    assign instr        = pwdata;   // decode register latches it this cycle
    assign host_we      = access & pwrite & is_reg & (state == idle);
    assign host_addr    = paddr[6:2];
    assign host_wdata   = pwdata;
    assign status_clear = access & pwrite & is_status;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else if (instr_valid) begin
            state <= wait_exec;
        end else if (state == wait_exec && wb_done) begin
            state <= idle;
        end
    end

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        if (access) begin
            if (state == wait_exec) begin
                pready = wb_done;                  // fourth access cycle
            end else if (!(is_instr && pwrite)) begin
                pready  = 1'b1;
                pslverr = !(is_instr || is_status || is_reg);
            end
        end
    end

    always_comb begin
        prdata = '0;                               // also the instr reg readback
        if (is_reg) begin
            prdata = host_rdata;
        end else if (is_status) begin
            prdata = mips_pkg::word_t'(status);
        end
    end

endmodule

// ==== hw/mips_exec_top.sv ====
`timescale 1ns/1ps

module mips_exec_top #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  mips_pkg::word_t       pwdata,
    output mips_pkg::word_t       prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic                instr_valid;
    mips_pkg::word_t     instr;
    logic                dec_valid;
    mips_pkg::alu_op_t   alu_op;
    logic                var_shift;
    logic                use_imm;
    logic                reg_write;
    logic                undefined;
    mips_pkg::word_t     imm;
    logic [4:0]          shamt;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t waddr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    logic                ex_valid;
    mips_pkg::word_t     ex_result;
    mips_pkg::reg_addr_t ex_waddr;
    logic                ex_write;
    logic                ex_overflow;
    logic                ex_undefined;
    logic                wb_done;
    logic                host_we;
    mips_pkg::reg_addr_t host_addr;
    mips_pkg::word_t     host_wdata;
    mips_pkg::word_t     host_rdata;
    logic                status_clear;
    logic [1:0]          status;

    apb_front #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_apb_front (
        .clk          (clk),
        .arst_n       (arst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .wb_done      (wb_done),
        .host_rdata   (host_rdata),
        .status       (status),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .status_clear (status_clear)
    );

    instr_decode u_instr_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .alu_op      (alu_op),
        .var_shift   (var_shift),
        .use_imm     (use_imm),
        .reg_write   (reg_write),
        .undefined   (undefined),
        .imm         (imm),
        .shamt       (shamt),
        .rs          (rs),
        .rt          (rt),
        .waddr       (waddr)
    );

    alu_execute u_alu_execute (
        .clk          (clk),
        .arst_n       (arst_n),
        .dec_valid    (dec_valid),
        .alu_op       (alu_op),
        .var_shift    (var_shift),
        .use_imm      (use_imm),
        .reg_write    (reg_write),
        .undefined    (undefined),
        .imm          (imm),
        .shamt        (shamt),
        .waddr        (waddr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .ex_valid     (ex_valid),
        .ex_result    (ex_result),
        .ex_waddr     (ex_waddr),
        .ex_write     (ex_write),
        .ex_overflow  (ex_overflow),
        .ex_undefined (ex_undefined)
    );

    reg_writeback u_reg_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .rs           (rs),
        .rt           (rt),
        .ex_valid     (ex_valid),
        .ex_result    (ex_result),
        .ex_waddr     (ex_waddr),
        .ex_write     (ex_write),
        .ex_overflow  (ex_overflow),
        .ex_undefined (ex_undefined),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .status_clear (status_clear),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .host_rdata   (host_rdata),
        .wb_done      (wb_done),
        .status       (status)
    );

endmodule

// ==== testbench/mips_exec_chk.sv ====
`timescale 1ns/1ps

module mips_exec_chk (
    input logic clk,
    input logic arst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic instr_valid
);

    int assert_fails = 0;

    ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> (psel && penable))
        else begin
            assert_fails++;
            $error("pready high outside an access phase");
        end

    slverr_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> pready)
        else begin
            assert_fails++;
            $error("pslverr high without pready");
        end

    instr_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |=> !instr_valid)
        else begin
            assert_fails++;
            $error("instr_valid longer than one cycle");
        end

    // decode, execute, writeback, then ready
    instr_four_cycles: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> !pready ##1 !pready ##1 !pready ##1 pready)
        else begin
            assert_fails++;
            $error("instruction write did not complete in its fourth access cycle");
        end

endmodule

bind apb_front mips_exec_chk u_chk (
    .clk         (clk),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr),
    .instr_valid (instr_valid)
);

// ==== testbench/tb_mips_exec.sv ====
`timescale 1ns/1ps

module tb_mips_exec;

    localparam int addr_width = 8;
    localparam int max_cycles = 400 * 6 + 100;  // 400 transactions of up to 6 cycles each

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    mips_pkg::word_t       pwdata;
    mips_pkg::word_t       prdata;
    logic                  pready;
    logic                  pslverr;

    integer          seed = 32'hfef71325;
    int              checks = 0;
    int              errors = 0;
    int              cycle_count = 0;
    mips_pkg::word_t model_regs [0:31];
    logic [1:0]      model_status;

    mips_exec_top #(
        .ADDR_WIDTH (addr_width)
    ) dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the test did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input mips_pkg::word_t got,
                               input mips_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // one APB transfer with outputs sampled at the falling edge
    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input mips_pkg::word_t wdata,
                            output mips_pkg::word_t rdata, output logic err, output int cycles);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic host_write_reg(input mips_pkg::reg_addr_t idx, input mips_pkg::word_t data);
        mips_pkg::word_t rdata;
        logic            err;
        int              cycles;
        apb_xfer(mips_pkg::addr_reg_base + {idx, 2'b00}, 1'b1, data, rdata, err, cycles);
        check_value("pslverr", {31'd0, err}, 32'd0);
        check_value("access_cycles", cycles, 32'd1);
        if (idx != 0) model_regs[idx] = data;
    endtask

    task automatic expect_reg(input mips_pkg::reg_addr_t idx);
        mips_pkg::word_t rdata;
        logic            err;
        int              cycles;
        apb_xfer(mips_pkg::addr_reg_base + {idx, 2'b00}, 1'b0, '0, rdata, err, cycles);
        check_value($sformatf("prdata r%0d", idx), rdata, model_regs[idx]);
        check_value("access_cycles", cycles, 32'd1);
    endtask

    task automatic expect_status();
        mips_pkg::word_t rdata;
        logic            err;
        int              cycles;
        apb_xfer(mips_pkg::addr_status, 1'b0, '0, rdata, err, cycles);
        check_value("status", rdata, {30'd0, model_status});
        check_value("access_cycles", cycles, 32'd1);
    endtask

    task automatic clear_status();
        mips_pkg::word_t rdata;
        logic            err;
        int              cycles;
        rdata = $random(seed);                       // any data clears
        apb_xfer(mips_pkg::addr_status, 1'b1, rdata, rdata, err, cycles);
        check_value("access_cycles", cycles, 32'd1);
        model_status = 2'b00;
    endtask

    // reference model of one instruction that returns its destination
    task automatic model_exec(input mips_pkg::word_t iw, output mips_pkg::reg_addr_t dest);
        logic [5:0]      op;
        logic [5:0]      fn;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t r;
        mips_pkg::word_t simm;
        mips_pkg::word_t zimm;
        logic [4:0]      sh;
        logic            ovf;
        logic            und;
        op   = iw[31:26];
        fn   = iw[5:0];
        a    = model_regs[iw[25:21]];
        b    = model_regs[iw[20:16]];
        simm = {{16{iw[15]}}, iw[15:0]};
        zimm = {16'h0000, iw[15:0]};
        sh   = iw[10:6];
        dest = iw[20:16];
        r    = '0;
        ovf  = 1'b0;
        und  = 1'b0;
        if (op == mips_pkg::op_special) begin
            dest = iw[15:11];
            case (fn)
                mips_pkg::fn_and:  r = a & b;
                mips_pkg::fn_or:   r = a | b;
                mips_pkg::fn_xor:  r = a ^ b;
                mips_pkg::fn_nor:  r = ~(a | b);
                mips_pkg::fn_add: begin
                    r   = a + b;
                    ovf = (a[31] == b[31]) && (r[31] != a[31]);
                end
                mips_pkg::fn_addu: r = a + b;
                mips_pkg::fn_sub: begin
                    r   = a - b;
                    ovf = (a[31] != b[31]) && (r[31] != a[31]);
                end
                mips_pkg::fn_subu: r = a - b;
                mips_pkg::fn_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_pkg::fn_sltu: r = (a < b) ? 32'd1 : 32'd0;
                mips_pkg::fn_sll:  r = b << sh;
                mips_pkg::fn_srl:  r = b >> sh;
                mips_pkg::fn_sra:  r = $signed(b) >>> sh;
                mips_pkg::fn_sllv: r = b << a[4:0];
                mips_pkg::fn_srlv: r = b >> a[4:0];
                mips_pkg::fn_srav: r = $signed(b) >>> a[4:0];
                default:           und = 1'b1;
            endcase
        end else begin
            case (op)
                mips_pkg::op_addi: begin
                    r   = a + simm;
                    ovf = (a[31] == simm[31]) && (r[31] != a[31]);
                end
                mips_pkg::op_addiu: r = a + simm;
                mips_pkg::op_slti:  r = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                mips_pkg::op_sltiu: r = (a < simm) ? 32'd1 : 32'd0;
                mips_pkg::op_andi:  r = a & zimm;
                mips_pkg::op_ori:   r = a | zimm;
                mips_pkg::op_xori:  r = a ^ zimm;
                mips_pkg::op_lui:   r = {iw[15:0], 16'h0000};
                default:            und = 1'b1;
            endcase
        end
        if (und) begin
            model_status[mips_pkg::status_undef_bit] = 1'b1;
        end else if (ovf) begin
            model_status[mips_pkg::status_ovf_bit] = 1'b1;
        end else if (dest != 0) begin
            model_regs[dest] = r;
        end
    endtask

    task automatic issue_instr(input mips_pkg::word_t iw);
        mips_pkg::word_t     rdata;
        mips_pkg::reg_addr_t dest;
        logic                err;
        int                  cycles;
        apb_xfer(mips_pkg::addr_instr, 1'b1, iw, rdata, err, cycles);
        check_value("pslverr", {31'd0, err}, 32'd0);
        check_value("instr_cycles", cycles, 32'd4);
        model_exec(iw, dest);
        expect_reg(dest);
    endtask

    function automatic logic [5:0] funct_at(input int i);
        case (i)
            0:  return mips_pkg::fn_and;
            1:  return mips_pkg::fn_or;
            2:  return mips_pkg::fn_xor;
            3:  return mips_pkg::fn_nor;
            4:  return mips_pkg::fn_add;
            5:  return mips_pkg::fn_addu;
            6:  return mips_pkg::fn_sub;
            7:  return mips_pkg::fn_subu;
            8:  return mips_pkg::fn_slt;
            9:  return mips_pkg::fn_sltu;
            10: return mips_pkg::fn_sll;
            11: return mips_pkg::fn_srl;
            12: return mips_pkg::fn_sra;
            13: return mips_pkg::fn_sllv;
            14: return mips_pkg::fn_srlv;
            default: return mips_pkg::fn_srav;
        endcase
    endfunction

    function automatic logic [5:0] opcode_at(input int i);
        case (i)
            0: return mips_pkg::op_addi;
            1: return mips_pkg::op_addiu;
            2: return mips_pkg::op_slti;
            3: return mips_pkg::op_sltiu;
            4: return mips_pkg::op_andi;
            5: return mips_pkg::op_ori;
            6: return mips_pkg::op_xori;
            default: return mips_pkg::op_lui;
        endcase
    endfunction

    task automatic make_instr(output mips_pkg::word_t iw);
        logic [31:0] rnd;
        int          pick;
        logic [5:0]  op;
        logic [5:0]  fn;
        rnd  = $random(seed);
        pick = rnd[7:0] % 34;
        iw   = $random(seed);                        // random register and imm fields
        fn   = iw[5:0];
        if (pick < 16) begin
            op = mips_pkg::op_special;
            fn = funct_at(pick);
        end else if (pick < 32) begin
            op = opcode_at(pick % 8);
        end else if (pick == 32) begin
            op = mips_pkg::op_special;
            fn = {2'b11, iw[3:0]};                   // no kept funct up here
        end else begin
            op = {1'b1, iw[30:26]};                  // loads, stores and the like
        end
        iw = {op, iw[25:6], fn};
    endtask

    function automatic logic is_mapped(input logic [7:0] a);
        return (a == mips_pkg::addr_instr) || (a == mips_pkg::addr_status) ||
               (a[7] && a[1:0] == 2'b00);
    endfunction

    initial begin
        mips_pkg::word_t rdata;
        logic [31:0]     rnd;
        logic [7:0]      addr;
        logic            err;
        int              cycles;
        int              i;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        arst_n  = 1'b0;
        for (i = 0; i < 32; i++) model_regs[i] = '0;
        model_status = 2'b00;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        expect_status();
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            expect_reg(rnd[4:0]);
        end

        repeat (40) begin
            rnd = $random(seed);
            host_write_reg(rnd[4:0], $random(seed));
        end
        for (i = 0; i < 32; i++) expect_reg(i);
        apb_xfer(mips_pkg::addr_instr, 1'b0, '0, rdata, err, cycles);
        check_value("prdata instr", rdata, 32'd0);

        // overflow and undefined cases
        host_write_reg(1, 32'h7fffffff);
        host_write_reg(2, 32'h00000001);
        host_write_reg(5, 32'h80000000);
        issue_instr({mips_pkg::op_special, 5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::fn_add});
        expect_status();
        clear_status();
        expect_status();
        issue_instr({mips_pkg::op_addi, 5'd1, 5'd4, 16'h0001});
        issue_instr({mips_pkg::op_special, 5'd5, 5'd2, 5'd6, 5'd0, mips_pkg::fn_sub});
        expect_status();
        clear_status();
        issue_instr({6'h23, 5'd1, 5'd7, 16'h0010});
        expect_status();
        clear_status();

        for (i = 0; i < 100; i++) begin
            make_instr(rdata);
            issue_instr(rdata);
            if (i % 10 == 9) begin
                expect_status();
                clear_status();
            end
        end

        repeat (10) begin
            rnd  = $random(seed);
            addr = rnd[7:0];
            while (is_mapped(addr)) begin
                rnd  = $random(seed);
                addr = rnd[7:0];
            end
            apb_xfer(addr, rnd[8], $random(seed), rdata, err, cycles);
            check_value("pslverr", {31'd0, err}, 32'd1);
            check_value("access_cycles", cycles, 32'd1);
        end
        expect_status();
        for (i = 0; i < 32; i++) expect_reg(i);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_apb_front.u_chk.assert_fails);
        if (errors == 0 && dut.u_apb_front.u_chk.assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/mips_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/reg_writeback.sv
hw/apb_front.sv
hw/mips_exec_top.sv
testbench/mips_exec_chk.sv
testbench/tb_mips_exec.sv
